/* arcade_pkg.sv */
// Shared key-event and control types plus PS/2 scan codes, imported by the keyboard and control path
package arcade_pkg;

	// ==============================
	// Key event
	// ==============================

	// One decoded keyboard event as it leaves the PS/2 receiver
	// The prefixes are already folded into the two flag bits
	typedef struct packed {
		// Scan code of the key itself, never a prefix byte
		logic [7:0] code;
		// An E0 prefix came before the code
		logic       ext;
		// An F0 prefix came before the code, so the key was released
		logic       brk;
	} key_event_t;

	// ==============================
	// Game controls
	// ==============================

	// Control vector handed to the game core, one bit per input, active high
	// The mapper also keeps its held-key state in this shape (before rotation)
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
		logic bomb;
		logic start1;
		logic start2;
		logic coin;
	} controls_t;

	// ==============================
	// Scan codes, set 2
	// ==============================

	// Prefix bytes that modify the next code
	localparam logic [7:0] SC_PREFIX_EXT = 8'hE0;
	localparam logic [7:0] SC_PREFIX_BRK = 8'hF0;

	// Arrow keys, all of them only valid behind an E0 prefix
	// Without the prefix these codes are keypad keys and mean nothing here
	localparam logic [7:0] SC_UP    = 8'h75;
	localparam logic [7:0] SC_DOWN  = 8'h72;
	localparam logic [7:0] SC_LEFT  = 8'h6B;
	localparam logic [7:0] SC_RIGHT = 8'h74;

	// Space bar fires, left control drops a bomb
	localparam logic [7:0] SC_FIRE = 8'h29;
	localparam logic [7:0] SC_BOMB = 8'h14;

	// Number row keys 1 and 2 start the game for one or two players
	localparam logic [7:0] SC_START1 = 8'h16;
	localparam logic [7:0] SC_START2 = 8'h1E;

	// Key 5 inserts a coin, as on most arcade front ends
	localparam logic [7:0] SC_COIN = 8'h2E;

endpackage

/* ps2_rx.sv */
// PS/2 keyboard receiver that decodes frames into key events and pushes them against a credit count
`timescale 1ns/10ps

module ps2_rx import arcade_pkg::*; #(
	parameter int EVT_DEPTH  = 4,
	parameter int PS2_FILTER = 4
) (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       ps2_clk,
	input  logic       ps2_data,
	input  logic       credit,
	output logic       evt_push,
	output key_event_t evt,
	output logic       drop,
	output logic       parity_err
);

	// Filter counter only needs to reach PS2_FILTER-1
	localparam int FLT_W = (PS2_FILTER > 1) ? $clog2(PS2_FILTER) : 1;
	// Credit counter holds 0 up to EVT_DEPTH inclusive
	localparam int CRD_W = $clog2(EVT_DEPTH + 1);

	logic [1:0]       clk_sync;
	logic [1:0]       data_sync;
	logic             clk_flt;
	logic [FLT_W-1:0] flt_cnt;
	logic             flt_settle;
	logic             ps2_fall;
	logic [3:0]       bit_cnt;
	logic [9:0]       shift;
	logic             frame_done;
	logic             frame_ok;
	logic [7:0]       code;
	logic             pend_ext;
	logic             pend_brk;
	logic [CRD_W-1:0] credit_cnt;
	logic             do_push;

	// ==============================
	// Line synchroniser and filter
	// ==============================

	// Both lines idle high, so the flops come out of reset high too
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			clk_sync  <= 2'b11;
			data_sync <= 2'b11;
		end else begin
			clk_sync  <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
		end
	end

	// The filtered clock follows only after the synced level has differed for PS2_FILTER cycles
	assign flt_settle = (clk_sync[1] != clk_flt) && (flt_cnt == FLT_W'(PS2_FILTER - 1));
	// A settle while the filtered clock is still high is a falling edge
	assign ps2_fall = flt_settle && clk_flt;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			clk_flt <= 1'b1;
			flt_cnt <= '0;
		end else if (clk_sync[1] == clk_flt) begin
			// Glitch shorter than the window, start counting again
			flt_cnt <= '0;
		end else if (flt_settle) begin
			clk_flt <= clk_sync[1];
			flt_cnt <= '0;
		end else begin
			flt_cnt <= flt_cnt + 1'b1;
		end
	end

	// ==============================
	// Frame shifter
	// ==============================

	// Bit 10 is the stop bit, sampled on the last falling edge of the frame
	assign frame_done = ps2_fall && (bit_cnt == 4'd10);

	// Counter waits at zero until a low start bit shows, which also resyncs after a bad frame
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt <= '0;
		end else if (ps2_fall) begin
			if (frame_done)
				bit_cnt <= '0;
			else if (bit_cnt != 4'd0 || !data_sync[1])
				bit_cnt <= bit_cnt + 4'd1;
		end
	end

	// Data arrives LSB first, after ten shifts start sits in bit 0 and parity in bit 9
	always_ff @(posedge clk_sys) begin
		if (ps2_fall && !frame_done)
			shift <= {data_sync[1], shift[9:1]};
	end

	assign code = shift[8:1];
	// Start low, stop high (still on the data line now) and odd parity over data plus parity bit
	assign frame_ok = !shift[0] && data_sync[1] && (^shift[9:1]);

	// Only a real code is pushed, and only while a buffer slot is known to be free
	assign do_push = frame_done && frame_ok && (code != SC_PREFIX_EXT) &&
		(code != SC_PREFIX_BRK) && (credit_cnt != '0);

	// ==============================
	// Prefix folding and credits
	// ==============================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			pend_ext   <= 1'b0;
			pend_brk   <= 1'b0;
			evt_push   <= 1'b0;
			drop       <= 1'b0;
			parity_err <= 1'b0;
			credit_cnt <= CRD_W'(EVT_DEPTH);
		end else begin
			evt_push <= do_push;
			// A returned credit and a push in the same cycle cancel out
			credit_cnt <= credit_cnt + CRD_W'(credit) - CRD_W'(do_push);
			if (frame_done) begin
				if (!frame_ok) begin
					// Bad frame also poisons any prefix collected so far
					parity_err <= 1'b1;
					pend_ext   <= 1'b0;
					pend_brk   <= 1'b0;
				end else if (code == SC_PREFIX_EXT) begin
					pend_ext <= 1'b1;
				end else if (code == SC_PREFIX_BRK) begin
					pend_brk <= 1'b1;
				end else begin
					pend_ext <= 1'b0;
					pend_brk <= 1'b0;
					// The keyboard cannot be stalled, so a code without credit is lost
					if (credit_cnt == '0)
						drop <= 1'b1;
				end
			end
		end
	end

	// Event payload is loaded together with the push strobe
	always_ff @(posedge clk_sys) begin
		if (do_push) begin
			evt.code <= code;
			evt.ext  <= pend_ext;
			evt.brk  <= pend_brk;
		end
	end

endmodule

/* key_event_buffer.sv */
// Circular key-event FIFO between the PS/2 receiver and the control mapper, sized by the credit count
`timescale 1ns/10ps

module key_event_buffer import arcade_pkg::*; #(
	parameter int EVT_DEPTH = 4
) (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       evt_push,
	input  key_event_t evt,
	input  logic       credit,
	output key_event_t head,
	output logic       head_valid
);

	localparam int PTR_W = (EVT_DEPTH > 1) ? $clog2(EVT_DEPTH) : 1;
	localparam int CNT_W = $clog2(EVT_DEPTH + 1);

	key_event_t       mem [EVT_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] occupancy;

	// Pointers wrap at EVT_DEPTH, so depths that are not a power of two work as well
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(EVT_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	// Storage, written on every push
	// There is no full check here, the producer never holds more credits than slots
	always_ff @(posedge clk_sys) begin
		if (evt_push)
			mem[wr_ptr] <= evt;
	end

	// The credit pulse from the mapper is the pop
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			occupancy <= '0;
		end else begin
			if (evt_push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (credit)
				rd_ptr <= ptr_inc(rd_ptr);
			occupancy <= occupancy + CNT_W'(evt_push) - CNT_W'(credit);
		end
	end

	// Oldest entry straight from storage, valid one cycle after its push
	assign head       = mem[rd_ptr];
	assign head_valid = (occupancy != '0);

endmodule

/* control_mapper.sv */
// Turns key events into held-key state and the game's control vector, with optional 90 degree rotation
`timescale 1ns/10ps

module control_mapper import arcade_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  key_event_t head,
	input  logic       head_valid,
	input  logic       rotate,
	output logic       credit,
	output controls_t  controls
);

	// Held keys in unrotated order, so held.up is the up arrow key itself
	controls_t held;
	controls_t held_nxt;
	controls_t mapped;
	logic      make;

	// Every valid head is consumed at once, which keeps the producer topped up with credits
	assign credit = head_valid;

	// A make event presses the key, a break event releases it
	assign make = !head.brk;

	// ==============================
	// Key decode
	// ==============================

	// Code and ext flag must both match, so keypad 8 (75 without E0) is not the up arrow
	always_comb begin
		held_nxt = held;
		if (head_valid) begin
			case ({head.ext, head.code})
				{1'b1, SC_UP}:     held_nxt.up     = make;
				{1'b1, SC_DOWN}:   held_nxt.down   = make;
				{1'b1, SC_LEFT}:   held_nxt.left   = make;
				{1'b1, SC_RIGHT}:  held_nxt.right  = make;
				{1'b0, SC_FIRE}:   held_nxt.fire   = make;
				{1'b0, SC_BOMB}:   held_nxt.bomb   = make;
				{1'b0, SC_START1}: held_nxt.start1 = make;
				{1'b0, SC_START2}: held_nxt.start2 = make;
				{1'b0, SC_COIN}:   held_nxt.coin   = make;
				// Anything else is popped and forgotten
				default: ;
			endcase
		end
	end

	// ==============================
	// Rotation
	// ==============================

	// For a monitor turned by 90 degrees the joystick directions turn with it
	// Buttons pass through untouched
	always_comb begin
		mapped = held_nxt;
		if (rotate) begin
			mapped.up    = held_nxt.left;
			mapped.down  = held_nxt.right;
			mapped.left  = held_nxt.down;
			mapped.right = held_nxt.up;
		end
	end

	// Both registers load from the next state, so controls moves in the cycle after the pop
	// A change on rotate alone also shows one cycle later
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			held     <= '0;
			controls <= '0;
		end else begin
			held     <= held_nxt;
			controls <= mapped;
		end
	end

endmodule

/* sigma_delta_dac.sv */
// First-order sigma-delta DAC that turns a signed 8-bit audio sample into a one-bit stream
`timescale 1ns/10ps

module sigma_delta_dac (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  logic signed [7:0] sample,
	output logic              dac_bit
);

	// Offset binary level, silence (0) sits at mid scale 128
	logic [7:0] level;
	// Bit 8 is the carry of the last add, bits 7..0 carry the error forward
	logic [8:0] acc;

	// Flipping the sign bit moves -128..127 onto 0..255
	assign level = {~sample[7], sample[6:0]};

	// The remainder is kept and the carry is dropped before the next add,
	// so over 256 cycles exactly level carries come out
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			acc <= '0;
		else
			acc <= {1'b0, acc[7:0]} + {1'b0, level};
	end

	// Carry is a flop output, no logic between it and the pin
	assign dac_bit = acc[8];

endmodule

/* arcade_io_top.sv */
// Top level of the keyboard control and audio path, instantiated by the board wrapper or the testbench
`timescale 1ns/10ps

module arcade_io_top import arcade_pkg::*; #(
	parameter int EVT_DEPTH  = 4,
	parameter int PS2_FILTER = 4
) (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  logic              ps2_clk,
	input  logic              ps2_data,
	input  logic              rotate,
	input  logic signed [7:0] audio,
	output controls_t         controls,
	output logic              drop,
	output logic              parity_err,
	output logic              audio_l,
	output logic              audio_r
);

	// Event channel between receiver, buffer and mapper
	logic       evt_push;
	key_event_t evt;
	key_event_t head;
	logic       head_valid;
	// One pulse pops the buffer and hands a slot back to the receiver
	logic       credit;
	logic       dac_bit;

	// ==============================
	// Keyboard path
	// ==============================

	ps2_rx #(
		.EVT_DEPTH  (EVT_DEPTH),
		.PS2_FILTER (PS2_FILTER)
	) ps2_rx_i (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.ps2_clk    (ps2_clk),
		.ps2_data   (ps2_data),
		.credit     (credit),
		.evt_push   (evt_push),
		.evt        (evt),
		.drop       (drop),
		.parity_err (parity_err)
	);

	key_event_buffer #(
		.EVT_DEPTH (EVT_DEPTH)
	) evt_buf_i (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.evt_push   (evt_push),
		.evt        (evt),
		.credit     (credit),
		.head       (head),
		.head_valid (head_valid)
	);

	control_mapper mapper_i (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.head       (head),
		.head_valid (head_valid),
		.rotate     (rotate),
		.credit     (credit),
		.controls   (controls)
	);

	// ==============================
	// Audio path
	// ==============================

	sigma_delta_dac dac_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.sample  (audio),
		.dac_bit (dac_bit)
	);

	// The game is mono, both channels carry the same stream
	assign audio_l = dac_bit;
	assign audio_r = dac_bit;

endmodule

/* arcade_io_sva.sv */
// Concurrent checks on the key-event buffer credit protocol and reset state, bound into key_event_buffer
`timescale 1ns/10ps

module arcade_io_sva #(
	parameter int EVT_DEPTH = 4
) (
	input logic                           clk_sys,
	input logic                           rst_n,
	input logic                           evt_push,
	input logic                           credit,
	input logic                           head_valid,
	input logic [$clog2(EVT_DEPTH+1)-1:0] occupancy
);

	// Running count of failed assertions, read by the testbench after the run
	int fail_cnt = 0;
	// Fill level rebuilt from the push and pop strobes alone, independent of the buffer's own count
	int fill;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			fill <= 0;
		else
			fill <= fill + int'(evt_push) - int'(credit);
	end

	// ==============================
	// Reset state
	// ==============================

	// While reset is held the buffer is empty and the channel is quiet
	reset_quiet: assert property (@(posedge clk_sys)
		!rst_n |-> (occupancy == 0) && !head_valid && !evt_push && !credit)
		else begin
			$error("Buffer or event channel active during reset");
			fail_cnt++;
		end

	// ==============================
	// Credit protocol
	// ==============================

	// An empty buffer must never claim a valid head
	empty_no_head: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(fill == 0) |-> !head_valid)
		else begin
			$error("head_valid set while the buffer is empty");
			fail_cnt++;
		end

	// The producer's credits bound the fill level, so it can never pass the depth
	no_overflow: assert property (@(posedge clk_sys) disable iff (!rst_n)
		occupancy <= EVT_DEPTH)
		else begin
			$error("Buffer occupancy %0d above depth %0d", occupancy, EVT_DEPTH);
			fail_cnt++;
		end

	// A pop is only legal on a valid head
	pop_on_valid: assert property (@(posedge clk_sys) disable iff (!rst_n)
		credit |-> head_valid)
		else begin
			$error("Credit returned while no event was at the head");
			fail_cnt++;
		end

endmodule

// Attach the checker to every buffer instance, reaching its internal occupancy count
bind key_event_buffer arcade_io_sva #(
	.EVT_DEPTH (EVT_DEPTH)
) sva_i (
	.clk_sys    (clk_sys),
	.rst_n      (rst_n),
	.evt_push   (evt_push),
	.credit     (credit),
	.head_valid (head_valid),
	.occupancy  (occupancy)
);

/* tb_arcade_io.sv */
// Testbench for arcade_io_top, replays PS/2 frames and audio samples from the golden data file
`timescale 1ns/10ps

module tb_arcade_io import arcade_pkg::*; ();

	// Cycles to wait for controls to match before giving up
	localparam int CTRL_TIMEOUT = 400;
	// Cycles the controls must then stay put
	localparam int SETTLE = 16;
	localparam int FLAG_TIMEOUT = 400;

	logic              clk_sys;
	logic              rst_n;
	logic              ps2_clk;
	logic              ps2_data;
	logic              rotate;
	logic signed [7:0] audio;
	controls_t         controls;
	logic              drop;
	logic              parity_err;
	logic              audio_l;
	logic              audio_r;

	int err_cnt;
	int timeout_cnt;

	arcade_io_top dut_i (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.ps2_clk    (ps2_clk),
		.ps2_data   (ps2_data),
		.rotate     (rotate),
		.audio      (audio),
		.controls   (controls),
		.drop       (drop),
		.parity_err (parity_err),
		.audio_l    (audio_l),
		.audio_r    (audio_r)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// ==============================
	// Helpers
	// ==============================

	// Inputs always change 2 ns after the rising edge, outputs are sampled there too
	task automatic wait_clk(input int n);
		repeat (n) @(posedge clk_sys);
		#2;
	endtask

	// Keyboard half period, 40 cycles with up to 7 cycles of jitter
	function automatic int half_period();
		return 40 + int'($urandom % 8);
	endfunction

	// One 11-bit frame, LSB first, odd parity unless a bad one is asked for
	task automatic send_frame(input logic [7:0] data, input logic bad_par);
		logic [10:0] frame;
		frame = {1'b1, (~^data) ^ bad_par, data, 1'b0};
		for (int i = 0; i < 11; i++) begin
			// Data moves while the clock is high and is taken on the falling edge
			ps2_data = frame[i];
			wait_clk(half_period());
			ps2_clk = 1'b0;
			wait_clk(half_period());
			ps2_clk = 1'b1;
		end
	endtask

	// Poll controls until they match, then make sure they hold
	task automatic check_controls(input logic [8:0] exp);
		int n;
		n = 0;
		while (controls !== exp && n < CTRL_TIMEOUT) begin
			wait_clk(1);
			n++;
		end
		if (n >= CTRL_TIMEOUT) begin
			$display("Timeout: controls did not reach %03h within %0d cycles", exp, CTRL_TIMEOUT);
			timeout_cnt++;
		end
		assert (controls === exp) else begin
			$display("ERR @%0t: controls %03h, expected %03h", $time, controls, exp);
			err_cnt++;
		end
		wait_clk(SETTLE);
		assert (controls === exp) else begin
			$display("ERR @%0t: controls moved to %03h, expected %03h", $time, controls, exp);
			err_cnt++;
		end
		assert (!drop) else begin
			$display("ERR @%0t: drop set although the mapper keeps up", $time);
			err_cnt++;
		end
	endtask

	// Count ones on audio_l over 256 cycles and compare with the offset binary level
	task automatic check_audio(input logic [7:0] smp, input int exp);
		int ones;
		ones = 0;
		audio = smp;
		wait_clk(4);
		for (int i = 0; i < 256; i++) begin
			assert (audio_r === audio_l) else begin
				$display("ERR @%0t: audio_r %b differs from audio_l %b", $time, audio_r, audio_l);
				err_cnt++;
			end
			if (audio_l)
				ones++;
			wait_clk(1);
		end
		assert (ones >= exp - 1 && ones <= exp + 1) else begin
			$display("ERR @%0t: sample %02h gave %0d ones, expected %0d", $time, smp, ones, exp);
			err_cnt++;
		end
	endtask

	// ==============================
	// Main sequence
	// ==============================

	initial begin
		int               fd;
		int               rc;
		int               n;
		int               rnd;
		int               cnt;
		logic [8*8-1:0]   cmd;
		logic [8*200-1:0] line;
		logic [7:0]       b;
		logic [8:0]       exp;
		err_cnt     = 0;
		timeout_cnt = 0;
		rst_n       = 1'b0;
		ps2_clk     = 1'b1;
		ps2_data    = 1'b1;
		rotate      = 1'b0;
		audio       = '0;
		rnd         = $urandom(32'hfa61);

		wait_clk(10);
		// Outputs must be at their reset values before release
		assert (controls === '0 && !drop && !parity_err && !audio_l && !audio_r) else begin
			$display("ERR @%0t: outputs not at reset values", $time);
			err_cnt++;
		end
		rst_n = 1'b1;
		wait_clk(5);

		fd = $fopen("arcade_io_golden.txt", "r");
		if (fd == 0) begin
			$display("Could not open the golden data file arcade_io_golden.txt");
			err_cnt++;
		end else begin
			while (!$feof(fd)) begin
				cmd = '0;
				rc = $fscanf(fd, "%s", cmd);
				if (rc != 1)
					break;
				if (cmd == "#") begin
					rc = $fgets(line, fd);
				end else if (cmd == "KEY") begin
					rc = $fscanf(fd, "%d", n);
					for (int i = 0; i < n; i++) begin
						rc = $fscanf(fd, "%h", b);
						send_frame(b, 1'b0);
					end
					rc = $fscanf(fd, "%h", exp);
					check_controls(exp);
				end else if (cmd == "ROT") begin
					rc = $fscanf(fd, "%d %h", n, exp);
					rotate = n[0];
					check_controls(exp);
				end else if (cmd == "BADPAR") begin
					rc = $fscanf(fd, "%h %h", b, exp);
					// Good frames so far must not have raised the sticky flag
					assert (!parity_err) else begin
						$display("ERR @%0t: parity_err already set before the bad frame", $time);
						err_cnt++;
					end
					send_frame(b, 1'b1);
					n = 0;
					while (!parity_err && n < FLAG_TIMEOUT) begin
						wait_clk(1);
						n++;
					end
					if (n >= FLAG_TIMEOUT) begin
						$display("Timeout: parity_err never rose after a bad frame");
						timeout_cnt++;
					end
					assert (parity_err) else begin
						$display("ERR @%0t: parity_err low after a bad frame", $time);
						err_cnt++;
					end
					check_controls(exp);
				end else if (cmd == "AUD") begin
					rc = $fscanf(fd, "%h %d", b, cnt);
					check_audio(b, cnt);
				end else begin
					$display("Unknown command %0s in the golden data file", cmd);
					err_cnt++;
				end
			end
			$fclose(fd);
		end

		assert (!drop) else begin
			$display("ERR @%0t: drop set at the end of the run", $time);
			err_cnt++;
		end

		// The bound buffer checker keeps its own tally of protocol violations
		assert (dut_i.evt_buf_i.sva_i.fail_cnt == 0) else begin
			$display("ERR @%0t: %0d bound assertion failures in the event buffer", $time,
				dut_i.evt_buf_i.sva_i.fail_cnt);
			err_cnt++;
		end

		$display("Run complete: %0d errors, %0d timeouts", err_cnt, timeout_cnt);
		if (err_cnt == 0 && timeout_cnt == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* arcade_io_golden.txt */
# KEY <n> <bytes> <controls> | ROT <rotate> <controls> | BADPAR <byte> <controls> | AUD <sample> <ones>
# controls hex, bit 8 to 0: up down left right fire bomb start1 start2 coin
KEY 1 29 010
KEY 2 F0 29 000
KEY 2 E0 75 100
KEY 3 E0 F0 75 000
KEY 1 75 000
KEY 2 F0 75 000
KEY 2 E0 6B 040
KEY 2 E0 74 060
KEY 1 2E 061
ROT 1 181
KEY 2 E0 75 1A1
KEY 1 16 1A5
ROT 0 165
KEY 9 E0 F0 75 E0 F0 6B E0 F0 74 005
KEY 4 F0 2E F0 16 000
BADPAR 14 000
KEY 1 14 008
KEY 2 F0 14 000
KEY 7 29 14 16 1E 2E E0 72 09F
KEY 6 F0 29 F0 14 F0 1E 085
ROT 1 045
ROT 0 085
KEY 7 E0 F0 72 F0 16 F0 2E 000
AUD 00 128
AUD 7F 255
AUD 80 0
AUD 40 192
AUD C0 64
AUD 01 129

/* compile.f */
arcade_pkg.sv
ps2_rx.sv
key_event_buffer.sv
control_mapper.sv
sigma_delta_dac.sv
arcade_io_top.sv
arcade_io_sva.sv
tb_arcade_io.sv

/* Bender.yml */
package:
  name: arcade_io

sources:
  - arcade_pkg.sv
  - ps2_rx.sv
  - key_event_buffer.sv
  - control_mapper.sv
  - sigma_delta_dac.sv
  - arcade_io_top.sv
  - target: test
    files:
      - arcade_io_sva.sv
      - tb_arcade_io.sv
